// ==== aluUnit.sv ====
`default_nettype none

module aluUnit import mipsPkg::*; (
	input logic [31:0] a,
	input logic [31:0] b,
	input aluOp_t aluOp,
	output logic [31:0] result,
	output logic zero
);

	// single-cycle alu, no flags beyond zero
	always_comb begin
		case (aluOp)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			// signed compare, result is 0 or 1
			aluSlt: result = {31'b0, $signed(a) < $signed(b)};
			// upper half from the immediate
			aluLui: result = b << 16;
			default: result = '0;
		endcase
	end

	// branches resolve in decode, zero kept for execute use
	assign zero = (result == 32'd0);

endmodule

`default_nettype wire

// ==== controlDecoder.sv ====
`default_nettype none

module controlDecoder import mipsPkg::*; (
	input instr_t instrD,
	output logic regWriteD,
	output logic memToRegD,
	output logic memWriteD,
	output logic aluSrcD,
	output logic regDstD,
	output logic branchD,
	output logic branchNeD,
	output logic jumpD,
	output logic zeroExtD,
	output aluOp_t aluOpD
);

	always_comb begin
		// defaults describe a bubble
		regWriteD = 1'b0;
		memToRegD = 1'b0;
		memWriteD = 1'b0;
		aluSrcD = 1'b0;
		regDstD = 1'b0;
		branchD = 1'b0;
		branchNeD = 1'b0;
		jumpD = 1'b0;
		zeroExtD = 1'b0;
		aluOpD = aluAdd;
		case (instrD.rType.op)
			opRtype: begin
				// rd destination, funct picks the op
				regDstD = 1'b1;
				regWriteD = 1'b1;
				case (instrD.rType.funct)
					fnAddu: aluOpD = aluAdd;
					fnSubu: aluOpD = aluSub;
					fnAnd: aluOpD = aluAnd;
					fnOr: aluOpD = aluOr;
					fnSlt: aluOpD = aluSlt;
					// unsupported funct, drop the write
					default: regWriteD = 1'b0;
				endcase
			end
			opAddiu: begin
				regWriteD = 1'b1;
				aluSrcD = 1'b1;
			end
			opOri: begin
				regWriteD = 1'b1;
				aluSrcD = 1'b1;
				zeroExtD = 1'b1;
				aluOpD = aluOr;
			end
			opLui: begin
				regWriteD = 1'b1;
				aluSrcD = 1'b1;
				zeroExtD = 1'b1;
				aluOpD = aluLui;
			end
			opLw: begin
				// address is base plus offset
				regWriteD = 1'b1;
				memToRegD = 1'b1;
				aluSrcD = 1'b1;
			end
			opSw: begin
				memWriteD = 1'b1;
				aluSrcD = 1'b1;
			end
			opBeq: branchD = 1'b1;
			opBne: begin
				branchD = 1'b1;
				branchNeD = 1'b1;
			end
			opJ: jumpD = 1'b1;
			// unknown opcode stays a bubble
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== datapath.sv ====
`default_nettype none

module datapath import mipsPkg::*; #(
	parameter logic [31:0] resetPc = 32'hbfc0_0000
) (
	input logic clk,
	input logic arstN,
	// instruction memory
	output logic [31:0] pcF,
	input logic [31:0] instrF,
	// data memory
	output logic memWriteM,
	output logic [31:0] aluOutM,
	output logic [31:0] writeDataM,
	input logic [31:0] readDataM,
	// decoder
	output instr_t instrD,
	input logic regWriteD,
	input logic memToRegD,
	input logic memWriteD,
	input logic aluSrcD,
	input logic regDstD,
	input aluOp_t aluOpD,
	input logic branchD,
	input logic branchNeD,
	input logic jumpD,
	input logic zeroExtD,
	// hazard unit inputs
	output logic [4:0] rsD,
	output logic [4:0] rtD,
	output logic [4:0] rsE,
	output logic [4:0] rtE,
	output logic [4:0] writeRegE,
	output logic regWriteE,
	output logic memToRegE,
	output logic [4:0] writeRegM,
	output logic regWriteM,
	output logic memToRegM,
	output logic [4:0] writeRegW,
	output logic regWriteW,
	// hazard unit outputs
	input logic stallF,
	input logic stallD,
	input logic flushE,
	input logic fwdAD,
	input logic fwdBD,
	input fwdSel_t fwdAE,
	input fwdSel_t fwdBE,
	input logic longestStall,
	// writeback trace
	output logic [31:0] debugWbPc,
	output logic [3:0] debugWbRfWen,
	output logic [4:0] debugWbRfWnum,
	output logic [31:0] debugWbRfWdata
);

	logic [31:0] pcPlus4F, pcNextF;
	logic [31:0] pcD, pcPlus4D, rd1D, rd2D, immD;
	logic [31:0] branchTargetD, jumpTargetD, cmpAD, cmpBD;
	logic [4:0] rdD;
	logic branchTakenD;
	logic memWriteE, aluSrcE, regDstE;
	aluOp_t aluOpE;
	logic [31:0] rd1E, rd2E, immE, pcE, srcAE, srcBE, writeDataE, aluOutE;
	logic [4:0] rdE;
	logic [31:0] pcM;
	logic memToRegW;
	logic [31:0] aluOutW, readDataW, pcW, resultW;

	// execute operand from regfile, mem or wb
	function automatic logic [31:0] fwdPick(
		input fwdSel_t sel,
		input logic [31:0] regVal,
		input logic [31:0] memVal,
		input logic [31:0] wbVal
	);
		case (sel)
			fwdMem: return memVal;
			fwdWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	//////////////////////////////
	// fetch
	assign pcPlus4F = pcF + 32'd4;
	// jump beats branch beats sequential
	assign pcNextF = jumpD ? jumpTargetD : branchTakenD ? branchTargetD : pcPlus4F;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pcF <= resetPc;
		end else if (!stallF) begin
			pcF <= pcNextF;
		end
	end

	// f/d, no decode flush, delay slot always runs
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			instrD <= '0;
			pcD <= '0;
			pcPlus4D <= '0;
		end else if (!stallD) begin
			instrD <= instrF;
			pcD <= pcF;
			pcPlus4D <= pcPlus4F;
		end
	end

	//////////////////////////////
	// decode
	assign rsD = instrD.iType.rs;
	assign rtD = instrD.iType.rt;
	assign rdD = instrD.rType.rd;
	assign immD = zeroExtD ? {16'h0000, instrD.iType.imm} :
		{{16{instrD.iType.imm[15]}}, instrD.iType.imm};
	// branch offset always sign-extended, word scaled
	assign branchTargetD = pcPlus4D + {{14{instrD.iType.imm[15]}}, instrD.iType.imm, 2'b00};
	// 26-bit target inside the delay slot's region
	assign jumpTargetD = {pcPlus4D[31:28], instrD.iType.rs, instrD.iType.rt,
		instrD.iType.imm, 2'b00};

	regFile u_regFile (
		.clk(clk),
		.arstN(arstN),
		.ra1(rsD),
		.ra2(rtD),
		.wa3(writeRegW),
		.we3(regWriteW),
		.wd3(resultW),
		.rd1(rd1D),
		.rd2(rd2D)
	);

	// early compare, mem result forwarded in
	assign cmpAD = fwdAD ? aluOutM : rd1D;
	assign cmpBD = fwdBD ? aluOutM : rd2D;
	assign branchTakenD = branchD & ((cmpAD == cmpBD) ^ branchNeD);

	// d/e, flush drops controls only, pc stays for the trace
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWriteE <= 1'b0;
			memToRegE <= 1'b0;
			memWriteE <= 1'b0;
			aluSrcE <= 1'b0;
			regDstE <= 1'b0;
			aluOpE <= aluAdd;
			{rd1E, rd2E, immE, pcE} <= '0;
			{rsE, rtE, rdE} <= '0;
		end else if (!longestStall) begin
			regWriteE <= regWriteD & ~flushE;
			memToRegE <= memToRegD & ~flushE;
			memWriteE <= memWriteD & ~flushE;
			aluSrcE <= aluSrcD;
			regDstE <= regDstD;
			aluOpE <= aluOpD;
			{rd1E, rd2E, immE, pcE} <= {rd1D, rd2D, immD, pcD};
			{rsE, rtE, rdE} <= {rsD, rtD, rdD};
		end
	end

	//////////////////////////////
	// execute
	assign srcAE = fwdPick(fwdAE, rd1E, aluOutM, resultW);
	assign writeDataE = fwdPick(fwdBE, rd2E, aluOutM, resultW);
	assign srcBE = aluSrcE ? immE : writeDataE;
	assign writeRegE = regDstE ? rdE : rtE;

	aluUnit u_aluUnit (
		.a(srcAE),
		.b(srcBE),
		.aluOp(aluOpE),
		.result(aluOutE),
		.zero()
	);

	// e/m
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWriteM <= 1'b0;
			memToRegM <= 1'b0;
			memWriteM <= 1'b0;
			{aluOutM, writeDataM, pcM} <= '0;
			writeRegM <= '0;
		end else if (!longestStall) begin
			regWriteM <= regWriteE;
			memToRegM <= memToRegE;
			memWriteM <= memWriteE;
			{aluOutM, writeDataM, pcM} <= {aluOutE, writeDataE, pcE};
			writeRegM <= writeRegE;
		end
	end

	//////////////////////////////
	// m/w, held too while memory stalls
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWriteW <= 1'b0;
			memToRegW <= 1'b0;
			{aluOutW, readDataW, pcW} <= '0;
			writeRegW <= '0;
		end else if (!longestStall) begin
			regWriteW <= regWriteM;
			memToRegW <= memToRegM;
			{aluOutW, readDataW, pcW} <= {aluOutM, readDataM, pcM};
			writeRegW <= writeRegM;
		end
	end

	assign resultW = memToRegW ? readDataW : aluOutW;

	// report a write once, in its last held cycle
	assign debugWbPc = pcW;
	assign debugWbRfWen = {4{regWriteW & ~longestStall}};
	assign debugWbRfWnum = writeRegW;
	assign debugWbRfWdata = resultW;

endmodule

`default_nettype wire

// ==== filelist.f ====
mipsPkg.sv
aluUnit.sv
regFile.sv
controlDecoder.sv
hazardUnit.sv
datapath.sv
mipsCore.sv
tbMipsCore_asserts.sv
tbChecker.sv
tbMipsCore.sv

// ==== hazardUnit.sv ====
`default_nettype none

module hazardUnit import mipsPkg::*; (
	input logic clk,
	input logic arstN,
	input logic [4:0] rsD,
	input logic [4:0] rtD,
	input logic [4:0] rsE,
	input logic [4:0] rtE,
	input logic [4:0] writeRegE,
	input logic [4:0] writeRegM,
	input logic [4:0] writeRegW,
	input logic branchD,
	input logic regWriteE,
	input logic memToRegE,
	input logic regWriteM,
	input logic memToRegM,
	input logic regWriteW,
	input logic iStall,
	input logic dStall,
	output logic stallF,
	output logic stallD,
	output logic flushE,
	output logic fwdAD,
	output logic fwdBD,
	output logic longestStall,
	output fwdSel_t fwdAE,
	output fwdSel_t fwdBE
);

	logic lwStall;
	logic branchStall;
	logic eBubble;

	// producer writes the register a consumer reads, r0 excluded
	function automatic logic hits(input logic we, input logic [4:0] dst, input logic [4:0] src);
		return we && (dst != 5'd0) && (dst == src);
	endfunction

	// youngest producer first
	function automatic fwdSel_t pickFwd(
		input logic [4:0] src,
		input logic weM,
		input logic [4:0] dstM,
		input logic weW,
		input logic [4:0] dstW
	);
		if (hits(weM, dstM, src))
			return fwdMem;
		else if (hits(weW, dstW, src))
			return fwdWb;
		return fwdReg;
	endfunction

	assign fwdAE = pickFwd(rsE, regWriteM, writeRegM, regWriteW, writeRegW);
	assign fwdBE = pickFwd(rtE, regWriteM, writeRegM, regWriteW, writeRegW);

	// branch compare in decode, alu result from mem only
	assign fwdAD = hits(regWriteM, writeRegM, rsD);
	assign fwdBD = hits(regWriteM, writeRegM, rtD);

	// load in execute feeding the next instruction
	assign lwStall = ~eBubble & (hits(memToRegE, writeRegE, rsD) | hits(memToRegE, writeRegE, rtD));

	// branch waits for a result in execute, or a load still in mem
	assign branchStall = branchD & ((~eBubble & (hits(regWriteE, writeRegE, rsD) |
		hits(regWriteE, writeRegE, rtD))) |
		hits(memToRegM, writeRegM, rsD) | hits(memToRegM, writeRegM, rtD));

	// memory back-pressure freezes everything
	assign longestStall = iStall | dStall;
	assign stallF = lwStall | branchStall | longestStall;
	assign stallD = lwStall | branchStall | longestStall;
	assign flushE = (lwStall | branchStall) & ~longestStall;

	// execute slot known empty after a flush, skip its compare
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			eBubble <= 1'b1;
		end else if (!longestStall) begin
			eBubble <= flushE;
		end
	end

endmodule

`default_nettype wire

// ==== mipsCore.sv ====
`default_nettype none

module mipsCore import mipsPkg::*; #(
	parameter logic [31:0] resetPc = 32'hbfc0_0000
) (
	input logic clk,
	input logic arstN,
	output logic [31:0] pcF,
	input logic [31:0] instrF,
	output logic memWriteM,
	output logic [31:0] aluOutM,
	output logic [31:0] writeDataM,
	input logic [31:0] readDataM,
	input logic iStall,
	input logic dStall,
	output logic longestStall,
	output logic [31:0] debugWbPc,
	output logic [3:0] debugWbRfWen,
	output logic [4:0] debugWbRfWnum,
	output logic [31:0] debugWbRfWdata
);

	// decode controls
	instr_t instrD;
	logic regWriteD, memToRegD, memWriteD, aluSrcD, regDstD;
	logic branchD, branchNeD, jumpD, zeroExtD;
	aluOp_t aluOpD;

	// hazard detection and forwarding
	logic [4:0] rsD, rtD, rsE, rtE;
	logic [4:0] writeRegE, writeRegM, writeRegW;
	logic regWriteE, memToRegE, regWriteM, memToRegM, regWriteW;
	logic stallF, stallD, flushE, fwdAD, fwdBD;
	fwdSel_t fwdAE, fwdBE;

	// port names match across the three blocks
	datapath #(.resetPc(resetPc)) u_datapath (.*);

	controlDecoder u_controlDecoder (.*);

	hazardUnit u_hazardUnit (.*);

endmodule

`default_nettype wire

// ==== mipsPkg.sv ====
`default_nettype none

package mipsPkg;

	//////////////////////////////
	// opcode field, bits 31:26
	localparam logic [5:0] opRtype = 6'h00;
	localparam logic [5:0] opJ     = 6'h02;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opBne   = 6'h05;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opOri   = 6'h0d;
	localparam logic [5:0] opLui   = 6'h0f;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opSw    = 6'h2b;

	// funct field of r-type, bits 5:0
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnSlt  = 6'h2a;

	//////////////////////////////
	// execute stage alu select
	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui} aluOp_t;

	// operand source in execute, mem wins over wb
	typedef enum logic [1:0] {fwdReg, fwdWb, fwdMem} fwdSel_t;

	// one instruction word, two field layouts
	// jump target is rs, rt and imm of the i-type view read together
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rType;
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} iType;
	} instr_t;

endpackage

`default_nettype wire

// ==== regFile.sv ====
`default_nettype none

module regFile (
	input logic clk,
	input logic arstN,
	input logic [4:0] ra1,
	input logic [4:0] ra2,
	input logic [4:0] wa3,
	input logic we3,
	input logic [31:0] wd3,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	logic [31:0] regMem [32];

	// write port, register zero never stored
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 32; i++) begin
				regMem[i] <= '0;
			end
		end else if (we3 && wa3 != 5'd0) begin
			regMem[wa3] <= wd3;
		end
	end

	// read ports, same-cycle write passes straight through
	// so writeback to decode needs no forward path
	assign rd1 = (ra1 == 5'd0) ? 32'd0 : (we3 && ra1 == wa3) ? wd3 : regMem[ra1];
	assign rd2 = (ra2 == 5'd0) ? 32'd0 : (we3 && ra2 == wa3) ? wd3 : regMem[ra2];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tbMipsCore -f filelist.f -o simMipsCore
./obj_dir/simMipsCore 2>&1 | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
	echo "simulation reported errors, see sim.log"
	exit 1
fi
echo "simulation finished without errors"

// ==== tbChecker.sv ====
`default_nettype none

module tbChecker #(
	parameter logic [31:0] resetPc = 32'h0,
	parameter int traceLen = 1,
	parameter int pcLen = 1,
	parameter int storeLen = 1
) (
	input logic clk,
	input logic arstN,
	input logic [31:0] pcF,
	input logic memWriteM,
	input logic [31:0] aluOutM,
	input logic [31:0] writeDataM,
	input logic longestStall,
	input logic [31:0] debugWbPc,
	input logic [3:0] debugWbRfWen,
	input logic [4:0] debugWbRfWnum,
	input logic [31:0] debugWbRfWdata,
	input logic [31:0] expPc [pcLen],
	input logic [31:0] expWrPc [traceLen],
	input logic [4:0] expWrReg [traceLen],
	input logic [31:0] expWrVal [traceLen],
	input logic [31:0] expStAddr [storeLen],
	input logic [31:0] expStData [storeLen],
	output logic done,
	output int wrErrs,
	output int pcErrs,
	output int stErrs,
	output int otherErrs
);

	// positions in the three expected tables
	int wrIdx;
	int pcIdx;
	int stIdx;
	logic [31:0] lastPc;
	logic seenReset = 1'b0;
	logic prevLow = 1'b0;

	// one line per wrong value, returns 1 on a mismatch
	function automatic int compareWord(input string name, input logic [31:0] expV,
		input logic [31:0] actV);
		if (expV !== actV) begin
			$display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
				$time, name, expV, actV);
			return 1;
		end
		return 0;
	endfunction

	assign done = seenReset && wrIdx == traceLen && pcIdx == pcLen && stIdx == storeLen;

	// sampled mid-cycle, away from the rising edge
	always @(negedge clk) begin
		if (!arstN) begin
			if (!seenReset) begin
				wrIdx = 0;
				pcIdx = 0;
				stIdx = 0;
				wrErrs = 0;
				pcErrs = 0;
				stErrs = 0;
				otherErrs = 0;
			end
			seenReset = 1'b1;
			// pc trace starts from the reset bubble
			lastPc = 32'd0;
			otherErrs += compareWord("pcF", resetPc, pcF);
			if (memWriteM || debugWbRfWen != 4'h0 || longestStall) begin
				$display("ERROR time=%0t store, register write or stall active in reset", $time);
				otherErrs++;
			end
		end else if (seenReset) begin
			// first cycle out of reset, fetch still at the reset vector
			if (prevLow) begin
				otherErrs += compareWord("pcF", resetPc, pcF);
			end

			//////////////////////////////
			// register write trace
			if (debugWbRfWen != 4'h0) begin
				if (wrIdx < traceLen) begin
					wrErrs += compareWord("debugWbPc", expWrPc[wrIdx], debugWbPc);
					wrErrs += compareWord("debugWbRfWnum", 32'(expWrReg[wrIdx]),
						32'(debugWbRfWnum));
					wrErrs += compareWord("debugWbRfWdata", expWrVal[wrIdx], debugWbRfWdata);
					wrIdx++;
				end else begin
					$display("ERROR time=%0t register r%0d written after the last expected write",
						$time, debugWbRfWnum);
					otherErrs++;
				end
			end

			// retire order, one entry per change of the wb pc
			if (debugWbPc != lastPc) begin
				if (pcIdx < pcLen) begin
					pcErrs += compareWord("debugWbPc", expPc[pcIdx], debugWbPc);
					pcIdx++;
				end
				lastPc = debugWbPc;
			end

			//////////////////////////////
			// a store lands on the next rising edge
			if (memWriteM && !longestStall) begin
				if (stIdx < storeLen) begin
					stErrs += compareWord("aluOutM", expStAddr[stIdx], aluOutM);
					stErrs += compareWord("writeDataM", expStData[stIdx], writeDataM);
					stIdx++;
				end else begin
					$display("ERROR time=%0t store to %h after the last expected store",
						$time, aluOutM);
					otherErrs++;
				end
			end
		end
		prevLow = !arstN;
	end

endmodule

`default_nettype wire

// ==== tbMipsCore.sv ====
`default_nettype none

module tbMipsCore import mipsPkg::*; ();

	localparam logic [31:0] resetPc = 32'h0040_0000;
	localparam int clkPeriod = 40;
	localparam int progLen = 34;
	localparam int traceLen = 21;
	localparam int pcLen = 31;
	localparam int storeLen = 3;
	localparam int maxCycles = (progLen + 20) * 8;
	// program indices in retire order, skipped words left out
	localparam int retireIdx [pcLen] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 15,
		17, 18, 20, 21, 22, 23, 24, 25, 27, 28, 29, 30, 31, 32, 33};

	logic clk = 1'b0;
	logic arstN;
	logic iStall;
	logic dStall;
	logic [31:0] instrF, readDataM, pcF, aluOutM, writeDataM;
	logic memWriteM, longestStall;
	logic [31:0] debugWbPc, debugWbRfWdata;
	logic [3:0] debugWbRfWen;
	logic [4:0] debugWbRfWnum;
	logic [31:0] fetchWord;
	logic stallOn;
	logic done;
	int wrErrs, pcErrs, stErrs, otherErrs;
	int wrFill;

	logic [31:0] progRom [progLen];
	logic [31:0] dataRam [64];
	logic [31:0] expPc [pcLen];
	logic [31:0] expWrPc [traceLen];
	logic [4:0] expWrReg [traceLen];
	logic [31:0] expWrVal [traceLen];
	logic [31:0] expStAddr [storeLen];
	logic [31:0] expStData [storeLen];

	always #(clkPeriod / 2) clk = ~clk;

	mipsCore #(.resetPc(resetPc)) u_mipsCore (.*);

	tbChecker #(
		.resetPc(resetPc),
		.traceLen(traceLen),
		.pcLen(pcLen),
		.storeLen(storeLen)
	) u_tbChecker (.*);

	//////////////////////////////
	// instruction encoders
	function automatic logic [31:0] encR(input logic [5:0] fn, input int rd, input int rs,
		input int rt);
		return {opRtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input int rt, input int rs,
		input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] pcOf(input int idx);
		return resetPc + 32'(idx * 4);
	endfunction

	function automatic logic [31:0] encJ(input int idx);
		logic [31:0] target;
		target = pcOf(idx);
		return {opJ, target[27:2]};
	endfunction

	// two preloaded words, the rest a pattern of the byte address
	function automatic logic [31:0] dataInit(input int idx);
		case (idx)
			0: return 32'h1357_2468;
			1: return 32'h0f0f_0001;
			default: return 32'hda7a_0000 | 32'(idx * 4);
		endcase
	endfunction

	task automatic expectWrite(input int idx, input int rd, input logic [31:0] val);
		expWrPc[wrFill] = pcOf(idx);
		expWrReg[wrFill] = 5'(rd);
		expWrVal[wrFill] = val;
		wrFill++;
	endtask

	task automatic loadTables();
		progRom[0] = encI(opAddiu, 1, 0, 16'd5);
		progRom[1] = encI(opAddiu, 2, 0, 16'hfffd);
		progRom[2] = encR(fnAddu, 3, 1, 2);
		progRom[3] = encR(fnSubu, 4, 1, 2);
		progRom[4] = encR(fnAnd, 5, 3, 4);
		progRom[5] = encR(fnOr, 6, 3, 4);
		progRom[6] = encR(fnSlt, 7, 2, 1);
		progRom[7] = encR(fnSlt, 8, 1, 2);
		progRom[8] = encI(opLui, 9, 0, 16'h1234);
		progRom[9] = encI(opOri, 9, 9, 16'h5678);
		progRom[10] = encI(opSw, 9, 0, 16'd8);
		progRom[11] = encI(opLw, 10, 0, 16'd8);
		progRom[12] = encR(fnAddu, 11, 10, 1);
		progRom[13] = encI(opLw, 12, 0, 16'd4);
		// taken, waits for the load in mem
		progRom[14] = encI(opBeq, 12, 12, 16'd2);
		progRom[15] = encI(opAddiu, 13, 0, 16'd7);
		progRom[16] = encI(opAddiu, 13, 0, 16'd99);
		// taken, compare forwarded from mem
		progRom[17] = encI(opBne, 0, 13, 16'd2);
		progRom[18] = encI(opOri, 14, 0, 16'h00ff);
		progRom[19] = encI(opAddiu, 14, 0, 16'd1);
		// both not taken
		progRom[20] = encI(opBeq, 2, 1, 16'd2);
		progRom[21] = encI(opAddiu, 15, 0, 16'h0011);
		progRom[22] = encI(opBne, 1, 1, 16'd2);
		progRom[23] = encI(opAddiu, 16, 0, 16'h0022);
		progRom[24] = encJ(27);
		progRom[25] = encI(opSw, 14, 1, 16'd11);
		progRom[26] = encI(opAddiu, 17, 0, 16'd1);
		progRom[27] = encI(opLw, 18, 0, 16'd16);
		progRom[28] = encR(fnSubu, 19, 18, 6);
		progRom[29] = encI(opSw, 19, 0, 16'd20);
		progRom[30] = encI(opLw, 20, 0, 16'd0);
		progRom[31] = encR(fnAddu, 21, 20, 12);
		// parked in a loop with a nop delay slot
		progRom[32] = encJ(32);
		progRom[33] = 32'h0000_0000;

		for (int i = 0; i < pcLen; i++) begin
			expPc[i] = pcOf(retireIdx[i]);
		end

		// hand-computed results, two's complement wrap
		wrFill = 0;
		expectWrite(0, 1, 32'h0000_0005);
		expectWrite(1, 2, 32'hffff_fffd);
		expectWrite(2, 3, 32'h0000_0002);
		expectWrite(3, 4, 32'h0000_0008);
		expectWrite(4, 5, 32'h0000_0000);
		expectWrite(5, 6, 32'h0000_000a);
		expectWrite(6, 7, 32'h0000_0001);
		expectWrite(7, 8, 32'h0000_0000);
		expectWrite(8, 9, 32'h1234_0000);
		expectWrite(9, 9, 32'h1234_5678);
		expectWrite(11, 10, 32'h1234_5678);
		expectWrite(12, 11, 32'h1234_567d);
		expectWrite(13, 12, 32'h0f0f_0001);
		expectWrite(15, 13, 32'h0000_0007);
		expectWrite(18, 14, 32'h0000_00ff);
		expectWrite(21, 15, 32'h0000_0011);
		expectWrite(23, 16, 32'h0000_0022);
		expectWrite(27, 18, 32'h0000_00ff);
		expectWrite(28, 19, 32'h0000_00f5);
		expectWrite(30, 20, 32'h1357_2468);
		expectWrite(31, 21, 32'h2266_2469);

		expStAddr[0] = 32'd8;
		expStData[0] = 32'h1234_5678;
		expStAddr[1] = 32'd16;
		expStData[1] = 32'h0000_00ff;
		expStAddr[2] = 32'd20;
		expStData[2] = 32'h0000_00f5;
	endtask

	//////////////////////////////
	// memory models, garbage while a stall hides the word
	assign fetchWord = (pcF - resetPc) >> 2;
	assign instrF = iStall ? 32'hdead_beef :
		(fetchWord < 32'(progLen)) ? progRom[fetchWord[5:0]] : 32'd0;
	assign readDataM = dStall ? 32'hbad0_da7a : dataRam[aluOutM[7:2]];
	assign stallOn = fetchWord >= 32'(progLen / 2);

	always @(posedge clk) begin
		if (!arstN) begin
			for (int i = 0; i < 64; i++) begin
				dataRam[i] <= dataInit(i);
			end
		end else if (memWriteM && !longestStall) begin
			dataRam[aluOutM[7:2]] <= writeDataM;
		end
	end

	task automatic printCounts();
		$display("errors: writes %0d, pc trace %0d, stores %0d, other %0d",
			wrErrs, pcErrs, stErrs, otherErrs);
	endtask

	initial begin
		void'($urandom(32'hb6cf_abdc));
		arstN = 1'b1;
		iStall = 1'b0;
		dStall = 1'b0;
		loadTables();
		@(posedge clk);
		arstN <= 1'b0;
		repeat (4) @(posedge clk);
		arstN <= 1'b1;
		// stall-free first half, random back-pressure in the second
		while (!done) begin
			@(posedge clk);
			iStall <= stallOn && ($urandom % 8 == 0);
			dStall <= stallOn && ($urandom % 8 == 0);
		end
		// drain, anything further is an extra write or store
		@(posedge clk);
		iStall <= 1'b0;
		dStall <= 1'b0;
		repeat (20) @(posedge clk);
		printCounts();
		if (wrErrs + pcErrs + stErrs + otherErrs == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(clkPeriod * (maxCycles + 5));
		$display("ERROR: watchdog expired after %0d cycles, the program did not finish",
			maxCycles);
		printCounts();
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tbMipsCore_asserts.sv ====
`default_nettype none

module mipsCoreAsserts (
	input logic clk,
	input logic arstN,
	input logic [31:0] pcF,
	input logic memWriteM,
	input logic longestStall,
	input logic [3:0] debugWbRfWen
);

	// no store leaves the core while reset is held
	memWriteInReset: assert property (@(posedge clk) !arstN |-> !memWriteM)
		else $error("memWriteM high while arstN is low");

	// byte enables of the trace move together
	wenAllOrNone: assert property (@(posedge clk) disable iff (!arstN)
		debugWbRfWen == 4'h0 || debugWbRfWen == 4'hf)
		else $error("debugWbRfWen partially set");

	// back-pressure freezes fetch
	pcHeldOnStall: assert property (@(posedge clk) disable iff (!arstN)
		longestStall |=> $stable(pcF))
		else $error("pcF moved under longestStall");

endmodule

bind mipsCore mipsCoreAsserts u_mipsCoreAsserts (
	.clk(clk),
	.arstN(arstN),
	.pcF(pcF),
	.memWriteM(memWriteM),
	.longestStall(longestStall),
	.debugWbRfWen(debugWbRfWen)
);

`default_nettype wire
